/* hdl/est_decode.sv */
`timescale 1ns/1ps
`include "est_consts.svh"

module est_decode (
   input  logic                nclk,
   input  logic                arst_n,
   input  logic                in_valid,
   input  est_op_pkg::op_e     in_op,
   input  est_op_pkg::tag_t    in_tag,
   input  est_fmt_pkg::fp32_t  in_operand,
   output logic                d_valid,
   output est_op_pkg::op_e     d_op,
   output est_op_pkg::tag_t    d_tag,
   output est_fmt_pkg::class_e d_class,
   output est_fmt_pkg::est_t   d_exp,
   output logic [4:0]          d_frac
);

   logic                exp_zero;
   logic                exp_ones;
   logic                frac_zero;
   est_fmt_pkg::class_e cls;
   est_fmt_pkg::est_t   unb_exp;

   assign exp_zero  = (in_operand.exp == 8'h00);
   assign exp_ones  = (in_operand.exp == 8'hff);
   assign frac_zero = (in_operand.frac == '0);

   // Denormals flush to zero whatever their sign
   always_comb begin
      if (exp_ones && !frac_zero) begin
         cls = est_fmt_pkg::CLS_INVALID;
      end else if (exp_zero) begin
         cls = est_fmt_pkg::CLS_ZERO;
      end else if (in_operand.sign) begin
         cls = est_fmt_pkg::CLS_INVALID;
      end else if (exp_ones) begin
         cls = est_fmt_pkg::CLS_INF;
      end else begin
         cls = est_fmt_pkg::CLS_NORMAL;
      end
   end

   // Normal exponents land in -126..127
   assign unb_exp = `EST_W'(in_operand.exp) - `EST_W'(`EST_BIAS);

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         d_valid <= 1'b0;
      end else begin
         d_valid <= in_valid;
      end
   end

   always_ff @(posedge nclk) begin
      if (in_valid) begin
         d_op    <= in_op;
         d_tag   <= in_tag;
         d_class <= cls;
         d_exp   <= unb_exp;
         d_frac  <= in_operand.frac[22:18];
      end
   end

endmodule

/* hdl/est_execute.sv */
`timescale 1ns/1ps
`include "est_consts.svh"

module est_execute (
   input  logic                nclk,
   input  logic                arst_n,
   input  logic                d_valid,
   input  est_op_pkg::op_e     d_op,
   input  est_op_pkg::tag_t    d_tag,
   input  est_fmt_pkg::class_e d_class,
   input  est_fmt_pkg::est_t   d_exp,
   input  logic [4:0]          d_frac,
   output logic                x_valid,
   output est_op_pkg::op_e     x_op,
   output est_op_pkg::tag_t    x_tag,
   output est_fmt_pkg::class_e x_class,
   output est_fmt_pkg::est_t   x_sum
);

   logic                 is_log2;
   logic                 in_corr;
   logic [`EST_FRAC-1:0] frac_bits;
   est_fmt_pkg::est_t    addend;
   est_fmt_pkg::est_t    corr;
   logic [0:`EST_W-1]    sum;

   assign is_log2   = (d_op == est_op_pkg::OP_LOG2);
   assign frac_bits = is_log2 ? d_frac[4 -: `EST_FRAC] : '0;
   assign in_corr   = (d_frac >= 5'(`EST_CORR_LO)) && (d_frac <= 5'(`EST_CORR_HI));

   // Shifting the exponent past the fraction field scales it by eight
   assign addend = {d_exp[`EST_W-`EST_FRAC-1:0], frac_bits};
   assign corr   = {{(`EST_W-1){1'b0}}, is_log2 && in_corr};

   // The adder wants both operands inverted
   fu_gst_add11 u_add (
      .a_b (~addend),
      .b_b (~corr),
      .s0  (sum)
   );

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         x_valid <= 1'b0;
      end else begin
         x_valid <= d_valid;
      end
   end

   always_ff @(posedge nclk) begin
      if (d_valid) begin
         x_op    <= d_op;
         x_tag   <= d_tag;
         x_class <= d_class;
         x_sum   <= sum;
      end
   end

endmodule

/* hdl/est_fmt_pkg.sv */
`include "est_consts.svh"

package est_fmt_pkg;

   // Zero also covers denormals, invalid covers NaN and negative operands
   typedef enum logic [1:0] {
      CLS_NORMAL  = 2'd0,
      CLS_ZERO    = 2'd1,
      CLS_INF     = 2'd2,
      CLS_INVALID = 2'd3
   } class_e;

   typedef struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] frac;
   } fp32_t;

   // Two's complement with EST_FRAC bits below the binary point
   typedef logic signed [`EST_W-1:0] est_t;

endpackage

/* hdl/est_op_pkg.sv */
package est_op_pkg;

   typedef enum logic {
      OP_GETEXP = 1'b0,
      OP_LOG2   = 1'b1
   } op_e;

   // At most one of these is set for any result
   typedef struct packed {
      logic invalid;
      logic zero;
      logic inf;
   } flags_t;

   typedef logic [3:0] tag_t;

endpackage

/* hdl/est_result.sv */
`timescale 1ns/1ps
`include "est_consts.svh"

module est_result (
   input  logic                nclk,
   input  logic                arst_n,
   input  logic                x_valid,
   input  est_op_pkg::op_e     x_op,
   input  est_op_pkg::tag_t    x_tag,
   input  est_fmt_pkg::class_e x_class,
   input  est_fmt_pkg::est_t   x_sum,
   output logic                out_valid,
   output est_op_pkg::tag_t    out_tag,
   output est_fmt_pkg::est_t   out_result,
   output est_op_pkg::flags_t  out_flags
);

   est_fmt_pkg::est_t  res_nxt;
   est_op_pkg::flags_t flg_nxt;

   always_comb begin
      flg_nxt = '0;
      // Get-exponent is an integer, so nothing may sit below the binary point
      if (x_op == est_op_pkg::OP_GETEXP) begin
         res_nxt = {x_sum[`EST_W-1:`EST_FRAC], {`EST_FRAC{1'b0}}};
      end else begin
         res_nxt = x_sum;
      end
      case (x_class)
         est_fmt_pkg::CLS_ZERO: begin
            res_nxt      = {1'b1, {(`EST_W-1){1'b0}}};
            flg_nxt.zero = 1'b1;
         end
         est_fmt_pkg::CLS_INF: begin
            res_nxt     = {1'b0, {(`EST_W-1){1'b1}}};
            flg_nxt.inf = 1'b1;
         end
         est_fmt_pkg::CLS_INVALID: begin
            res_nxt         = '0;
            flg_nxt.invalid = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         out_flags <= '0;
      end else begin
         out_valid <= x_valid;
         if (x_valid) begin
            out_flags <= flg_nxt;
         end
      end
   end

   always_ff @(posedge nclk) begin
      if (x_valid) begin
         out_tag    <= x_tag;
         out_result <= res_nxt;
      end
   end

endmodule

/* hdl/est_unit.sv */
`timescale 1ns/1ps

module est_unit (
   input  logic               nclk,
   input  logic               arst_n,
   input  logic               in_valid,
   input  est_op_pkg::op_e    in_op,
   input  est_op_pkg::tag_t   in_tag,
   input  est_fmt_pkg::fp32_t in_operand,
   output logic               out_valid,
   output est_op_pkg::tag_t   out_tag,
   output est_fmt_pkg::est_t  out_result,
   output est_op_pkg::flags_t out_flags
);

   logic                d_valid;
   est_op_pkg::op_e     d_op;
   est_op_pkg::tag_t    d_tag;
   est_fmt_pkg::class_e d_class;
   est_fmt_pkg::est_t   d_exp;
   logic [4:0]          d_frac;

   logic                x_valid;
   est_op_pkg::op_e     x_op;
   est_op_pkg::tag_t    x_tag;
   est_fmt_pkg::class_e x_class;
   est_fmt_pkg::est_t   x_sum;

   est_decode u_decode (
      .nclk       (nclk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_op      (in_op),
      .in_tag     (in_tag),
      .in_operand (in_operand),
      .d_valid    (d_valid),
      .d_op       (d_op),
      .d_tag      (d_tag),
      .d_class    (d_class),
      .d_exp      (d_exp),
      .d_frac     (d_frac)
   );

   est_execute u_execute (
      .nclk    (nclk),
      .arst_n  (arst_n),
      .d_valid (d_valid),
      .d_op    (d_op),
      .d_tag   (d_tag),
      .d_class (d_class),
      .d_exp   (d_exp),
      .d_frac  (d_frac),
      .x_valid (x_valid),
      .x_op    (x_op),
      .x_tag   (x_tag),
      .x_class (x_class),
      .x_sum   (x_sum)
   );

   est_result u_result (
      .nclk       (nclk),
      .arst_n     (arst_n),
      .x_valid    (x_valid),
      .x_op       (x_op),
      .x_tag      (x_tag),
      .x_class    (x_class),
      .x_sum      (x_sum),
      .out_valid  (out_valid),
      .out_tag    (out_tag),
      .out_result (out_result),
      .out_flags  (out_flags)
   );

endmodule

/* hdl/fu_gst_add11.sv */
`timescale 1ns/1ps
`include "est_consts.svh"

module fu_gst_add11 (
   input  logic [0:`EST_W-1] a_b,
   input  logic [0:`EST_W-1] b_b,
   output logic [0:`EST_W-1] s0
);

   localparam int L = `EST_W - 1;

   logic [0:L]   p1;
   logic [1:L]   g1;
   logic [1:L-1] t1;
   logic [1:L]   g2_b;
   logic [1:L-2] t2_b;
   logic [1:L]   g4;
   logic [1:L-4] t4;
   logic [1:L]   g8_b;
   logic [1:L-8] t8_b;
   logic [1:L]   c16;

   // Inputs arrive inverted, so NOR gives generate and NAND gives transmit
   assign p1 = a_b ^ b_b;
   assign g1 = ~(a_b[1:L] | b_b[1:L]);
   assign t1 = ~(a_b[1:L-1] & b_b[1:L-1]);

   // Levels alternate polarity; bit 0 is the MSB and carries flow toward it
   for (genvar i = 1; i <= L; i++) begin : g_prefix
      if (i + 1 <= L) begin : g_s2
         assign g2_b[i] = ~(g1[i] | (t1[i] & g1[i+1]));
      end else begin : g_s2_end
         assign g2_b[i] = ~g1[i];
      end
      if (i + 2 <= L) begin : g_s4
         assign g4[i] = ~(g2_b[i] & (t2_b[i] | g2_b[i+2]));
      end else begin : g_s4_end
         assign g4[i] = ~g2_b[i];
      end
      if (i + 4 <= L) begin : g_s8
         assign g8_b[i] = ~(g4[i] | (t4[i] & g4[i+4]));
      end else begin : g_s8_end
         assign g8_b[i] = ~g4[i];
      end
      if (i + 8 <= L) begin : g_s16
         assign c16[i] = ~(g8_b[i] & (t8_b[i] | g8_b[i+8]));
      end else begin : g_s16_end
         assign c16[i] = ~g8_b[i];
      end
   end

   for (genvar i = 1; i <= L - 2; i++) begin : g_t2
      assign t2_b[i] = ~(t1[i] & t1[i+1]);
   end

   for (genvar i = 1; i <= L - 4; i++) begin : g_t4
      assign t4[i] = ~(t2_b[i] | t2_b[i+2]);
   end

   for (genvar i = 1; i <= L - 8; i++) begin : g_t8
      assign t8_b[i] = ~(t4[i] & t4[i+4]);
   end

   // No carry into the LSB, and the carry out of bit 0 is dropped
   assign s0[0:L-1] = p1[0:L-1] ^ c16[1:L];
   assign s0[L]     = p1[L];

endmodule

/* include/est_consts.svh */
`ifndef EST_CONSTS_SVH
`define EST_CONSTS_SVH

// Fixed-point result width and the fraction bits kept below the binary point
`define EST_W       11
`define EST_FRAC    3

// Single-precision exponent bias
`define EST_BIAS    127

// Inclusive range of the five leading fraction bits where log2(1+f) sits far
// enough above f that the estimate gains one eighth
`define EST_CORR_LO 7
`define EST_CORR_HI 23

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the estimate unit testbench with Verilator and runs it
# The exit status is that of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module est_unit_tb -f verilog.f -o est_unit_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/est_unit_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0

/* sim/est_unit_tb.sv */
`timescale 1ns/1ps
`include "est_consts.svh"

module est_unit_tb;

   // The drive edge plus three register stages put the result four falling edges later
   localparam int LAT     = 4;
   localparam int TIMEOUT = 20;
   localparam int N_RAND  = 400;

   typedef struct packed {
      est_op_pkg::op_e   op;
      logic [31:0]       operand;
      logic [`EST_W-1:0] res;
      logic [2:0]        flg;
   } vec_t;

   typedef struct packed {
      logic [3:0]        tag;
      logic [`EST_W-1:0] res;
      logic [2:0]        flg;
      int                cyc;
   } pend_t;

   logic               nclk;
   logic               arst_n;
   logic               in_valid;
   est_op_pkg::op_e    in_op;
   est_op_pkg::tag_t   in_tag;
   est_fmt_pkg::fp32_t in_operand;
   logic               out_valid;
   est_op_pkg::tag_t   out_tag;
   est_fmt_pkg::est_t  out_result;
   est_op_pkg::flags_t out_flags;

   vec_t  vecs[$];
   pend_t exp_q[$];
   int    cyc;

   est_unit uut (
      .nclk       (nclk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_op      (in_op),
      .in_tag     (in_tag),
      .in_operand (in_operand),
      .out_valid  (out_valid),
      .out_tag    (out_tag),
      .out_result (out_result),
      .out_flags  (out_flags)
   );

   always #50 nclk = ~nclk;

   task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want) begin
         $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
         $display("TESTS FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   // Flags in the order invalid, zero, infinity above the 11-bit result
   function automatic logic [`EST_W+2:0] model(input est_op_pkg::op_e op, input logic [31:0] x);
      int         unb;
      int         idx;
      int         val;
      logic [2:0] flg;
      flg = 3'b000;
      unb = int'(x[30:23]) - `EST_BIAS;
      idx = int'(x[22:18]);
      val = unb * (1 << `EST_FRAC);
      if (op == est_op_pkg::OP_LOG2) begin
         val = val + int'(x[22:20]);
         if (idx >= `EST_CORR_LO && idx <= `EST_CORR_HI) begin
            val = val + 1;
         end
      end
      if (x[30:23] == 8'hff && x[22:0] != 23'd0) begin
         flg = 3'b100;
         val = 0;
      end else if (x[30:23] == 8'h00) begin
         flg = 3'b010;
         val = -(1 << (`EST_W - 1));
      end else if (x[31]) begin
         flg = 3'b100;
         val = 0;
      end else if (x[30:23] == 8'hff) begin
         flg = 3'b001;
         val = (1 << (`EST_W - 1)) - 1;
      end
      return {flg, val[`EST_W-1:0]};
   endfunction

   task automatic add_vec(input est_op_pkg::op_e op, input logic [31:0] operand,
                          input logic [`EST_W-1:0] res, input logic [2:0] flg);
      vec_t v;
      v.op      = op;
      v.operand = operand;
      v.res     = res;
      v.flg     = flg;
      vecs.push_back(v);
   endtask

   task automatic load_table();
      add_vec(est_op_pkg::OP_GETEXP, 32'h3F800000, 11'h000, 3'b000);
      add_vec(est_op_pkg::OP_GETEXP, 32'h40000000, 11'h008, 3'b000);
      add_vec(est_op_pkg::OP_GETEXP, 32'h3F400000, 11'h7F8, 3'b000);
      add_vec(est_op_pkg::OP_GETEXP, 32'h7F7FFFFF, 11'h3F8, 3'b000);
      add_vec(est_op_pkg::OP_GETEXP, 32'h00800000, 11'h410, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h3F800000, 11'h000, 3'b000);
      // Fraction index 6, just below the corrected range
      add_vec(est_op_pkg::OP_LOG2,   32'h3F980000, 11'h001, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h3F9C0000, 11'h002, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h3FC00000, 11'h005, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h3FDC0000, 11'h006, 3'b000);
      // Index 24 is the first one past the corrected range
      add_vec(est_op_pkg::OP_LOG2,   32'h3FE00000, 11'h006, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h40800000, 11'h010, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h3F400000, 11'h7FD, 3'b000);
      add_vec(est_op_pkg::OP_LOG2,   32'h7F7FFFFF, 11'h3FF, 3'b000);
      add_vec(est_op_pkg::OP_GETEXP, 32'h00000000, 11'h400, 3'b010);
      add_vec(est_op_pkg::OP_LOG2,   32'h00000001, 11'h400, 3'b010);
      add_vec(est_op_pkg::OP_GETEXP, 32'h7F800000, 11'h3FF, 3'b001);
      add_vec(est_op_pkg::OP_LOG2,   32'h7F800000, 11'h3FF, 3'b001);
      add_vec(est_op_pkg::OP_LOG2,   32'h7FC00000, 11'h000, 3'b100);
      add_vec(est_op_pkg::OP_GETEXP, 32'hBF800000, 11'h000, 3'b100);
      add_vec(est_op_pkg::OP_LOG2,   32'hFF800000, 11'h000, 3'b100);
      add_vec(est_op_pkg::OP_LOG2,   32'h80000000, 11'h400, 3'b010);
   endtask

   task automatic issue(input est_op_pkg::op_e op, input logic [31:0] operand,
                        input logic [3:0] tag, input logic [`EST_W-1:0] res,
                        input logic [2:0] flg);
      pend_t p;
      @(posedge nclk);
      in_valid   <= 1'b1;
      in_op      <= op;
      in_tag     <= tag;
      in_operand <= operand;
      p.tag = tag;
      p.res = res;
      p.flg = flg;
      p.cyc = cyc;
      exp_q.push_back(p);
   endtask

   task automatic idle();
      @(posedge nclk);
      in_valid <= 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(posedge nclk);
         waited++;
         if (waited > TIMEOUT) begin
            $display("timeout: the unit produced no result for %0d operations", exp_q.size());
            $display("TESTS FAILED");
            $fatal(1, "drain timeout");
         end
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge nclk) begin : watch
      pend_t p;
      cyc = cyc + 1;
      if (!arst_n) begin
         check({31'd0, out_valid}, 32'd0, "out_valid in reset");
         check({29'd0, out_flags}, 32'd0, "out_flags in reset");
      end else if (out_valid) begin
         if (exp_q.size() == 0) begin
            check(32'd1, 32'd0, "out_valid with nothing in flight");
         end else begin
            p = exp_q.pop_front();
            check({28'd0, out_tag}, {28'd0, p.tag}, "out_tag");
            check({21'd0, out_result}, {21'd0, p.res}, "out_result");
            check({29'd0, out_flags}, {29'd0, p.flg}, "out_flags");
            check(32'(cyc - p.cyc), 32'(LAT), "latency in falling edges");
         end
      end else if (exp_q.size() != 0 && cyc - exp_q[0].cyc >= LAT) begin
         $display("the unit produced no result for tag %0d in time", exp_q[0].tag);
         $display("TESTS FAILED");
         $fatal(1, "missing result");
      end
   end

   initial begin
      est_op_pkg::op_e   op;
      logic [31:0]       x;
      logic [`EST_W+2:0] m;
      nclk = 1'b0;
      cyc  = 0;
      arst_n     <= 1'b0;
      in_valid   <= 1'b0;
      in_op      <= est_op_pkg::OP_GETEXP;
      in_tag     <= '0;
      in_operand <= '0;
      void'($urandom(32'hcb46));
      load_table();
      repeat (3) @(posedge nclk);
      arst_n <= 1'b1;
      repeat (2) idle();
      for (int i = 0; i < vecs.size(); i++) begin
         issue(vecs[i].op, vecs[i].operand, 4'(i), vecs[i].res, vecs[i].flg);
      end
      idle();
      // Mostly positive operands so that normals dominate the sweep
      for (int i = 0; i < N_RAND; i++) begin
         x = $urandom();
         if ($urandom_range(3, 0) != 0) begin
            x[31] = 1'b0;
         end
         op = ($urandom_range(1, 0) == 1) ? est_op_pkg::OP_LOG2 : est_op_pkg::OP_GETEXP;
         m  = model(op, x);
         issue(op, x, 4'(i), m[`EST_W-1:0], m[`EST_W+2:`EST_W]);
         if ($urandom_range(7, 0) == 0) begin
            idle();
         end
      end
      idle();
      drain();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+include
hdl/est_fmt_pkg.sv
hdl/est_op_pkg.sv
hdl/fu_gst_add11.sv
hdl/est_decode.sv
hdl/est_execute.sv
hdl/est_result.sv
hdl/est_unit.sv
sim/est_unit_tb.sv
